/* opl_pkg.sv */
// shared sizes, register addresses and record layouts; OPL2 waveform and rhythm fields are not carried
package opl_pkg;

    localparam int NUM_SLOTS = 18;
    localparam int NUM_CH    = 9;
    localparam int DIV_CEN   = 4;
    localparam int CEN_CNT_W = $clog2(DIV_CEN);

    // register map
    localparam logic [7:0] ADDR_FNUM_LO   = 8'hA0;
    localparam logic [7:0] ADDR_FNUM_HI   = 8'hB0;
    localparam logic [7:0] ADDR_FB_CON    = 8'hC0;
    localparam logic [7:0] ADDR_TIMER_A   = 8'h02;
    localparam logic [7:0] ADDR_TIMER_B   = 8'h03;
    localparam logic [7:0] ADDR_TIMER_CTL = 8'h04;
    localparam logic [7:0] ADDR_DEPTH     = 8'hBD;

    typedef enum logic [2:0] {
        UPD_NONE    = 3'd0,
        UPD_MULT    = 3'd1,
        UPD_KSL_TL  = 3'd2,
        UPD_AR_DR   = 3'd3,
        UPD_SL_RR   = 3'd4,
        UPD_FNUM_LO = 3'd5,
        UPD_FNUM_HI = 3'd6,
        UPD_FB_CON  = 3'd7
    } upd_kind_e;

    // index is a slot for operator kinds, a channel for channel kinds
    typedef struct packed {
        upd_kind_e  kind;
        logic [4:0] index;
        logic [7:0] data;
    } upd_t;

    typedef struct packed {
        logic [7:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       flagen_a;
        logic       flagen_b;
        logic       clr_flag;
    } timer_ctl_t;

    typedef struct packed {
        logic       am;
        logic       vib;
        logic       eg_type;
        logic       ksr;
        logic [3:0] mult;
        logic [1:0] ksl;
        logic [5:0] tl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
    } op_params_t;

    typedef struct packed {
        logic [9:0] fnum;
        logic [2:0] block;
        logic       keyon;
        logic [2:0] fb;
        logic       con;
    } ch_params_t;

    typedef struct packed {
        logic [4:0] slot;
        logic [3:0] ch;
        logic       op;
        logic       am_dep;
        logic       vib_dep;
        op_params_t op_params;
        ch_params_t ch_params;
    } slot_out_t;

endpackage

/* opl_clk_div.sv */
// cenop is combinational from cen; the first cen after reset counts as pulse number one
`timescale 1ns/1ps

module opl_clk_div
    import opl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic cenop
);

    logic [CEN_CNT_W-1:0] cnt;

    // last cen of each group of DIV_CEN
    assign cenop = cen && (cnt == CEN_CNT_W'(DIV_CEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen) begin
            cnt <= cenop ? '0 : cnt + 1'b1;
        end
    end

endmodule

/* opl_mmr.sv */
// host writes are captured one clk before decode; no back-pressure, no read-back, no rhythm or CSM
`timescale 1ns/1ps

module opl_mmr
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] din,
    input  logic       write,
    input  logic       addr,
    output upd_t       upd,
    output logic       upd_valid,
    output timer_ctl_t tctl,
    output logic       am_dep,
    output logic       vib_dep
);

    logic       wr_q;
    logic       addr_q;
    logic [7:0] din_q;
    logic [7:0] sel_addr;
    logic [3:0] hi;
    logic [3:0] lo;
    logic       data_wr;
    logic       op_hit;
    logic       ch_hit;
    upd_kind_e  kind;
    logic [4:0] index;

    assign data_wr = wr_q & addr_q;
    assign hi      = sel_addr[7:4];
    assign lo      = sel_addr[3:0];

    // address to update command
    always_comb begin
        kind   = UPD_NONE;
        index  = '0;
        op_hit = 1'b0;
        ch_hit = 1'b0;
        if (hi >= 4'h2 && hi <= 4'h9 && sel_addr[4:3] != 2'b11 && sel_addr[2:0] <= 3'd5) begin
            op_hit = 1'b1;
            // slot = group * 6 + sub
            index  = 5'(sel_addr[4:3]) * 5'd6 + 5'(sel_addr[2:0]);
            case (hi[3:1])
                3'b001:  kind = UPD_MULT;
                3'b010:  kind = UPD_KSL_TL;
                3'b011:  kind = UPD_AR_DR;
                default: kind = UPD_SL_RR;
            endcase
        end else if (lo <= 4'd8) begin
            index = {1'b0, lo};
            case (hi)
                ADDR_FNUM_LO[7:4]: begin
                    kind   = UPD_FNUM_LO;
                    ch_hit = 1'b1;
                end
                ADDR_FNUM_HI[7:4]: begin
                    kind   = UPD_FNUM_HI;
                    ch_hit = 1'b1;
                end
                ADDR_FB_CON[7:4]: begin
                    kind   = UPD_FB_CON;
                    ch_hit = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q          <= 1'b0;
            sel_addr      <= '0;
            upd_valid     <= 1'b0;
            am_dep        <= 1'b0;
            vib_dep       <= 1'b0;
            tctl.value_a  <= '0;
            tctl.value_b  <= '0;
            tctl.load_a   <= 1'b0;
            tctl.load_b   <= 1'b0;
            tctl.flagen_a <= 1'b1;
            tctl.flagen_b <= 1'b1;
            tctl.clr_flag <= 1'b0;
        end else begin
            wr_q          <= write;
            upd_valid     <= data_wr & (op_hit | ch_hit);
            tctl.clr_flag <= 1'b0;
            if (wr_q && !addr_q) begin
                sel_addr <= din_q;
            end
            if (data_wr) begin
                case (sel_addr)
                    ADDR_TIMER_A: tctl.value_a <= din_q;
                    ADDR_TIMER_B: tctl.value_b <= din_q;
                    ADDR_TIMER_CTL: begin
                        // bit 7 only clears the flags
                        if (din_q[7]) begin
                            tctl.clr_flag <= 1'b1;
                        end else begin
                            tctl.flagen_a <= ~din_q[6];
                            tctl.flagen_b <= ~din_q[5];
                            tctl.load_b   <= din_q[1];
                            tctl.load_a   <= din_q[0];
                        end
                    end
                    ADDR_DEPTH: begin
                        am_dep  <= din_q[7];
                        vib_dep <= din_q[6];
                    end
                    default: ;
                endcase
            end
        end
    end

    // host capture and command payload
    always_ff @(posedge clk) begin
        din_q  <= din;
        addr_q <= addr;
        if (data_wr) begin
            upd.kind  <= kind;
            upd.index <= index;
            upd.data  <= din_q;
        end
    end

endmodule

/* opl_op_regs.sv */
// index must be a valid slot for operator kinds; read port is combinational
`timescale 1ns/1ps

module opl_op_regs
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  upd_t       upd,
    input  logic       upd_valid,
    input  logic [4:0] rd_slot,
    output op_params_t op_params
);

    op_params_t mem [NUM_SLOTS];

    assign op_params = mem[rd_slot];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (upd_valid) begin
            // only the fields of the addressed group change
            case (upd.kind)
                UPD_MULT: begin
                    mem[upd.index].am      <= upd.data[7];
                    mem[upd.index].vib     <= upd.data[6];
                    mem[upd.index].eg_type <= upd.data[5];
                    mem[upd.index].ksr     <= upd.data[4];
                    mem[upd.index].mult    <= upd.data[3:0];
                end
                UPD_KSL_TL: begin
                    mem[upd.index].ksl <= upd.data[7:6];
                    mem[upd.index].tl  <= upd.data[5:0];
                end
                UPD_AR_DR: begin
                    mem[upd.index].ar <= upd.data[7:4];
                    mem[upd.index].dr <= upd.data[3:0];
                end
                UPD_SL_RR: begin
                    mem[upd.index].sl <= upd.data[7:4];
                    mem[upd.index].rr <= upd.data[3:0];
                end
                default: ;
            endcase
        end
    end

endmodule

/* opl_ch_regs.sv */
// index must be a valid channel for channel kinds; read port is combinational
`timescale 1ns/1ps

module opl_ch_regs
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  upd_t       upd,
    input  logic       upd_valid,
    input  logic [3:0] rd_ch,
    output ch_params_t ch_params
);

    ch_params_t mem [NUM_CH];
    logic [3:0] wr_ch;

    // channel index fits in the low four bits
    assign wr_ch     = upd.index[3:0];
    assign ch_params = mem[rd_ch];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                mem[i] <= '0;
            end
        end else if (upd_valid) begin
            case (upd.kind)
                UPD_FNUM_LO: mem[wr_ch].fnum[7:0] <= upd.data;
                UPD_FNUM_HI: begin
                    mem[wr_ch].keyon     <= upd.data[5];
                    mem[wr_ch].block     <= upd.data[4:2];
                    mem[wr_ch].fnum[9:8] <= upd.data[1:0];
                end
                UPD_FB_CON: begin
                    mem[wr_ch].fb  <= upd.data[3:1];
                    mem[wr_ch].con <= upd.data[0];
                end
                default: ;
            endcase
        end
    end

endmodule

/* opl_timers.sv */
// both timers tick once per cenop; a flag rises 256-value cenops after loading
`timescale 1ns/1ps

module opl_timers
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cenop,
    input  timer_ctl_t tctl,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq
);

    // index 0 is timer A, index 1 is timer B
    logic [1:0][7:0] value;
    logic [1:0][7:0] cnt;
    logic [1:0]      load;
    logic [1:0]      load_q;
    logic [1:0]      flagen;
    logic [1:0]      run;
    logic [1:0]      flag;

    assign value  = {tctl.value_b, tctl.value_a};
    assign load   = {tctl.load_b, tctl.load_a};
    assign flagen = {tctl.flagen_b, tctl.flagen_a};
    // running once the reload after the load edge has happened
    assign run    = load & load_q;

    assign flag_a = flag[0];
    assign flag_b = flag[1];
    assign irq    = |flag;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q <= '0;
            flag   <= '0;
        end else begin
            load_q <= load;
            for (int i = 0; i < 2; i++) begin
                if (tctl.clr_flag) begin
                    flag[i] <= 1'b0;
                end else if (run[i] && cenop && cnt[i] == 8'hFF && flagen[i]) begin
                    flag[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (load[i] && !load_q[i]) begin
                cnt[i] <= value[i];
            end else if (run[i] && cenop) begin
                cnt[i] <= (cnt[i] == 8'hFF) ? value[i] : cnt[i] + 8'd1;
            end
        end
    end

endmodule

/* opl_slot_seq.sv */
// one record per cenop in fixed slot order 0..17; no back-pressure on the slot stream
`timescale 1ns/1ps

module opl_slot_seq
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cenop,
    input  op_params_t op_params,
    input  ch_params_t ch_params,
    input  logic       am_dep,
    input  logic       vib_dep,
    output logic [4:0] rd_slot,
    output logic [3:0] rd_ch,
    output slot_out_t  slot_out,
    output logic       slot_valid
);

    logic [4:0] slot_cnt;
    logic [1:0] grp;
    logic [2:0] sub;
    logic       carrier;
    logic [1:0] sub_mod;

    // channel = group*3 + sub mod 3
    assign carrier = (sub >= 3'd3);
    assign sub_mod = carrier ? 2'(sub - 3'd3) : sub[1:0];
    assign rd_slot = slot_cnt;
    assign rd_ch   = 4'(grp) * 4'd3 + 4'(sub_mod);

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt   <= '0;
            grp        <= '0;
            sub        <= '0;
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= cenop;
            if (cenop) begin
                if (slot_cnt == 5'(NUM_SLOTS - 1)) begin
                    slot_cnt <= '0;
                    grp      <= '0;
                    sub      <= '0;
                end else begin
                    slot_cnt <= slot_cnt + 5'd1;
                    if (sub == 3'd5) begin
                        sub <= '0;
                        grp <= grp + 2'd1;
                    end else begin
                        sub <= sub + 3'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cenop) begin
            slot_out.slot      <= slot_cnt;
            slot_out.ch        <= rd_ch;
            slot_out.op        <= carrier;
            slot_out.am_dep    <= am_dep;
            slot_out.vib_dep   <= vib_dep;
            slot_out.op_params <= op_params;
            slot_out.ch_params <= ch_params;
        end
    end

endmodule

/* opl_top.sv */
// a written value shows in slot records starting 3 or more clk after the data write
`timescale 1ns/1ps

module opl_top
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic       write,
    input  logic       addr,
    output slot_out_t  slot_out,
    output logic       slot_valid,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq
);

    logic       cenop;
    upd_t       upd;
    logic       upd_valid;
    timer_ctl_t tctl;
    logic       am_dep;
    logic       vib_dep;
    logic [4:0] rd_slot;
    logic [3:0] rd_ch;
    op_params_t op_params;
    ch_params_t ch_params;

    opl_clk_div u_div (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cenop (cenop)
    );

    opl_mmr u_mmr (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .write     (write),
        .addr      (addr),
        .upd       (upd),
        .upd_valid (upd_valid),
        .tctl      (tctl),
        .am_dep    (am_dep),
        .vib_dep   (vib_dep)
    );

    opl_op_regs u_op_regs (
        .clk       (clk),
        .rst       (rst),
        .upd       (upd),
        .upd_valid (upd_valid),
        .rd_slot   (rd_slot),
        .op_params (op_params)
    );

    opl_ch_regs u_ch_regs (
        .clk       (clk),
        .rst       (rst),
        .upd       (upd),
        .upd_valid (upd_valid),
        .rd_ch     (rd_ch),
        .ch_params (ch_params)
    );

    opl_timers u_timers (
        .clk    (clk),
        .rst    (rst),
        .cenop  (cenop),
        .tctl   (tctl),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq    (irq)
    );

    opl_slot_seq u_seq (
        .clk        (clk),
        .rst        (rst),
        .cenop      (cenop),
        .op_params  (op_params),
        .ch_params  (ch_params),
        .am_dep     (am_dep),
        .vib_dep    (vib_dep),
        .rd_slot    (rd_slot),
        .rd_ch      (rd_ch),
        .slot_out   (slot_out),
        .slot_valid (slot_valid)
    );

endmodule

/* tb_opl.sv */
// needs cen high after reset so that every slot_valid pulse marks one cenop; no read-back is checked
`timescale 1ns/1ps

module tb_opl
    import opl_pkg::*;
;

    // rows written over all tests, used to size the watchdog
    localparam int TOTAL_ROWS      = 114;
    localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 2 + 256 * DIV_CEN * 3 + 500;

    typedef struct packed {
        logic [7:0] a;
        logic [7:0] d;
    } row_t;

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic       write;
    logic       addr;
    slot_out_t  slot_out;
    logic       slot_valid;
    logic       flag_a;
    logic       flag_b;
    logic       irq;

    integer     seed;
    int         errors;
    int         rec_idx;
    row_t       rows[$];

    // reference copy of the register map
    op_params_t op_model [NUM_SLOTS];
    ch_params_t ch_model [NUM_CH];
    logic       am_model;
    logic       vib_model;

    opl_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .din        (din),
        .write      (write),
        .addr       (addr),
        .slot_out   (slot_out),
        .slot_valid (slot_valid),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // records seen since reset, so the expected slot is rec_idx mod 18
    always @(posedge clk) begin
        if (rst) begin
            rec_idx <= 0;
        end else if (slot_valid) begin
            rec_idx <= rec_idx + 1;
        end
    end

    task automatic check_slot(input slot_out_t got, input slot_out_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: slot_out slot %0d got %h expected %h",
                     $time, exp.slot, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAIL %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // decode rules of the register map, applied to the model
    task automatic model_write(input logic [7:0] a, input logic [7:0] d);
        int grp;
        int sub;
        int s;
        grp = int'(a[4:3]);
        sub = int'(a[2:0]);
        s   = grp * 6 + sub;
        if (a[7:4] >= 4'h2 && a[7:4] <= 4'h9) begin
            if (grp <= 2 && sub <= 5) begin
                case (a[7:4])
                    4'h2, 4'h3: begin
                        op_model[s].am      = d[7];
                        op_model[s].vib     = d[6];
                        op_model[s].eg_type = d[5];
                        op_model[s].ksr     = d[4];
                        op_model[s].mult    = d[3:0];
                    end
                    4'h4, 4'h5: begin
                        op_model[s].ksl = d[7:6];
                        op_model[s].tl  = d[5:0];
                    end
                    4'h6, 4'h7: begin
                        op_model[s].ar = d[7:4];
                        op_model[s].dr = d[3:0];
                    end
                    default: begin
                        op_model[s].sl = d[7:4];
                        op_model[s].rr = d[3:0];
                    end
                endcase
            end
        end else if (a == ADDR_DEPTH) begin
            am_model  = d[7];
            vib_model = d[6];
        end else if (a[3:0] <= 4'd8) begin
            case (a[7:4])
                4'hA: ch_model[a[3:0]].fnum[7:0] = d;
                4'hB: begin
                    ch_model[a[3:0]].keyon     = d[5];
                    ch_model[a[3:0]].block     = d[4:2];
                    ch_model[a[3:0]].fnum[9:8] = d[1:0];
                end
                4'hC: begin
                    ch_model[a[3:0]].fb  = d[3:1];
                    ch_model[a[3:0]].con = d[0];
                end
                default: ;
            endcase
        end
    endtask

    function automatic slot_out_t expected_record(input int s);
        slot_out_t e;
        int        grp;
        int        sub;
        int        ch;
        grp         = s / 6;
        sub         = s % 6;
        ch          = grp * 3 + sub % 3;
        e           = '0;
        e.slot      = 5'(s);
        e.ch        = 4'(ch);
        e.op        = (sub >= 3);
        e.am_dep    = am_model;
        e.vib_dep   = vib_model;
        e.op_params = op_model[s];
        e.ch_params = ch_model[ch];
        return e;
    endfunction

    task automatic add_row(input int a, input int d);
        row_t r;
        r.a = 8'(a);
        r.d = 8'(d);
        rows.push_back(r);
    endtask

    task automatic add_random_row(input int a);
        integer rnd;
        rnd = $random(seed);
        add_row(a, int'(rnd[7:0]));
    endtask

    // address write then data write, back to back
    task automatic apply_rows();
        foreach (rows[i]) begin
            model_write(rows[i].a, rows[i].d);
            @(negedge clk);
            write = 1'b1;
            addr  = 1'b0;
            din   = rows[i].a;
            @(negedge clk);
            addr  = 1'b1;
            din   = rows[i].d;
        end
        @(negedge clk);
        write = 1'b0;
        addr  = 1'b0;
        rows.delete();
    endtask

    task automatic next_record(output slot_out_t r, output int s);
        do begin
            @(negedge clk);
        end while (!slot_valid);
        r = slot_out;
        s = rec_idx % NUM_SLOTS;
    endtask

    task automatic skip_records(input int n);
        slot_out_t r;
        int        s;
        repeat (n) next_record(r, s);
    endtask

    task automatic check_round(input logic with_flags);
        slot_out_t r;
        int        s;
        repeat (NUM_SLOTS) begin
            next_record(r, s);
            check_slot(r, expected_record(s));
            if (with_flags) begin
                check_bit("flag_a", flag_a, 1'b0);
                check_bit("flag_b", flag_b, 1'b0);
                check_bit("irq", irq, 1'b0);
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the test sequence did not finish in %0d clk", WATCHDOG_CYCLES);
        $display("errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        slot_out_t r;
        int        s;
        int        n;
        seed      = 32'hed68_d201;
        errors    = 0;
        rst       = 1'b1;
        cen       = 1'b0;
        din       = '0;
        write     = 1'b0;
        addr      = 1'b0;
        am_model  = 1'b0;
        vib_model = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            op_model[i] = '0;
        end
        for (int i = 0; i < NUM_CH; i++) begin
            ch_model[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        cen = 1'b1;

        // reset state of the slot stream
        check_round(1'b1);
        n = 0;
        repeat (NUM_SLOTS * DIV_CEN) begin
            @(negedge clk);
            if (slot_valid) begin
                n++;
            end
        end
        check_count("slot_valid pulses per round", n, NUM_SLOTS);

        // all four operator groups of every slot, then unused addresses
        for (int sl = 0; sl < NUM_SLOTS; sl++) begin
            for (int g = 0; g < 4; g++) begin
                add_random_row(8'h20 * (g + 1) + (sl / 6) * 8 + sl % 6);
            end
        end
        add_random_row(8'h26);
        add_random_row(8'h47);
        add_random_row(8'h6E);
        add_random_row(8'h8F);
        add_random_row(8'h38);
        add_random_row(8'h5A);
        add_random_row(8'h7D);
        add_random_row(8'h98);
        apply_rows();
        skip_records(2 * NUM_SLOTS);
        check_round(1'b0);

        // channel registers
        for (int c = 0; c < NUM_CH; c++) begin
            add_random_row(ADDR_FNUM_LO + c);
            add_random_row(ADDR_FNUM_HI + c);
            add_random_row(ADDR_FB_CON + c);
        end
        apply_rows();
        skip_records(NUM_SLOTS);
        check_round(1'b0);

        // depth bits
        add_row(ADDR_DEPTH, 8'hC0);
        apply_rows();
        skip_records(NUM_SLOTS);
        check_round(1'b0);

        // timer A from 0xF0 rises after 16 cenops
        add_row(ADDR_TIMER_A, 8'hF0);
        add_row(ADDR_TIMER_CTL, 8'h01);
        apply_rows();
        for (int k = 1; k <= 17; k++) begin
            next_record(r, s);
            if (k <= 15) begin
                check_bit("flag_a", flag_a, 1'b0);
                check_bit("irq", irq, 1'b0);
            end else if (k == 17) begin
                check_bit("flag_a", flag_a, 1'b1);
                check_bit("irq", irq, 1'b1);
            end
        end
        add_row(ADDR_TIMER_CTL, 8'h80);
        apply_rows();
        // clear lands two clk after the data write
        repeat (3) @(negedge clk);
        check_bit("flag_a", flag_a, 1'b0);
        check_bit("irq", irq, 1'b0);
        add_row(ADDR_TIMER_CTL, 8'h00);
        apply_rows();

        // timer B running with its flag masked
        add_row(ADDR_TIMER_B, 8'h80);
        add_row(ADDR_TIMER_CTL, 8'h22);
        apply_rows();
        repeat (300) begin
            next_record(r, s);
            check_bit("flag_b", flag_b, 1'b0);
            check_bit("irq", irq, 1'b0);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
opl_pkg.sv
opl_clk_div.sv
opl_mmr.sv
opl_op_regs.sv
opl_ch_regs.sv
opl_timers.sv
opl_slot_seq.sv
opl_top.sv
tb_opl.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_opl -f sources.f -o sim_opl
./obj_dir/sim_opl | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation finished without errors"
